/* logic/mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Sv32 address widths
`define VALEN       32
`define PALEN       34

// Page number widths for 4 KiB pages
// VPN splits into two 10-bit table indices
`define PPNLEN      22
`define VPNLEN      20

// Entries in each TLB
// Fully associative with round-robin refill
`define TLB_ENTRIES 4

`endif

/* logic/mmu_pkg.sv */
`include "mmu_macros.svh"

package mmu_pkg;

    // Sv32 page table entry
    // Flag bits sit in the low byte, as in memory
    typedef struct packed {
        logic [`PPNLEN-1:0] ppn;
        logic [1:0]         rsw;
        logic               d;
        logic               a;
        logic               g;
        logic               u;
        logic               x;
        logic               w;
        logic               r;
        logic               v;
    } pte_t;

    // Payload stored per instruction TLB entry
    typedef struct packed {
        logic x;
    } iperm_t;

    // Payload stored per data TLB entry
    typedef struct packed {
        logic r;
        logic w;
        logic d;
    } dperm_t;

    // One-cycle page fault pulses
    typedef struct packed {
        logic inst;
        logic load;
        logic store;
    } fault_t;

    // Which TLB the current walk refills
    typedef enum logic {
        WALK_I = 1'b0,
        WALK_D = 1'b1
    } walk_src_e;

endpackage

/* logic/tlb.sv */
`include "mmu_macros.svh"

module tlb #(
    parameter type perm_t = logic
) (
    input  logic                  clk,
    input  logic                  arst_n_i,

    // Lookup from the requester
    input  logic                  req_i,
    input  logic [`VALEN-1:0]     vaddr_i,
    input  logic                  en_i,
    input  logic                  flush_i,

    // Refill from the walker
    input  logic                  refill_i,
    input  logic [`VPNLEN-1:0]    refill_vpn_i,
    input  mmu_pkg::pte_t         refill_pte_i,
    input  perm_t                 refill_perm_i,
    input  logic                  refill_4m_i,

    output logic                  hit_o,
    output logic                  miss_o,
    output logic [`PALEN-1:0]     paddr_o
);

    localparam int IDX_W = (`TLB_ENTRIES > 1) ? $clog2(`TLB_ENTRIES) : 1;

    // Entry storage
    logic [`TLB_ENTRIES-1:0]   valid_q;
    logic [`TLB_ENTRIES-1:0]   sp_q;
    logic [`VPNLEN-1:0]        vpn_q  [`TLB_ENTRIES];
    logic [`PPNLEN-1:0]        ppn_q  [`TLB_ENTRIES];
    perm_t                     perm_q [`TLB_ENTRIES];
    logic [IDX_W-1:0]          victim_q;

    // Lookup
    logic [`VPNLEN-1:0]        vpn;
    logic [`TLB_ENTRIES-1:0]   match;
    logic                      any_match;
    logic [`PPNLEN-1:0]        hit_ppn;
    logic                      hit_sp;
    logic [`PALEN-1:0]         xlat_paddr;

    assign vpn = vaddr_i[`VALEN-1:12];

    // VPN[1] always compares, VPN[0] only for 4 KiB entries
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (vpn_q[i][`VPNLEN-1:10] == vpn[`VPNLEN-1:10])
                && (sp_q[i] || (vpn_q[i][9:0] == vpn[9:0]));
        end
    end

    assign any_match = |match;

    // Lowest matching entry wins
    always_comb begin
        hit_ppn = '0;
        hit_sp  = 1'b0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_ppn = ppn_q[i];
                hit_sp  = sp_q[i];
            end
        end
    end

    // Superpage keeps vaddr[21:12] as part of the offset
    always_comb begin
        xlat_paddr = {hit_ppn, vaddr_i[11:0]};
        if (hit_sp) begin
            xlat_paddr[21:12] = vaddr_i[21:12];
        end
    end

    // Bare mode passes the address straight through
    assign paddr_o = en_i ? xlat_paddr : {{(`PALEN-`VALEN){1'b0}}, vaddr_i};
    assign hit_o   = en_i ? (req_i & any_match) : req_i;
    assign miss_o  = en_i & req_i & ~any_match;

    // Valid bits and round-robin victim
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (refill_i) begin
            valid_q[victim_q] <= 1'b1;
            if (victim_q == IDX_W'(`TLB_ENTRIES - 1)) begin
                victim_q <= '0;
            end else begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    // Entry contents, written with the valid bit
    always_ff @(posedge clk) begin
        if (refill_i && !flush_i) begin
            vpn_q[victim_q]  <= refill_vpn_i;
            ppn_q[victim_q]  <= refill_pte_i.ppn;
            sp_q[victim_q]   <= refill_4m_i;
            perm_q[victim_q] <= refill_perm_i;
        end
    end

endmodule

/* logic/ptw.sv */
`include "mmu_macros.svh"

module ptw (
    input  logic                  clk,
    input  logic                  arst_n_i,

    // Misses and addresses from both TLBs
    input  logic                  i_miss_i,
    input  logic                  d_miss_i,
    input  logic [`VALEN-1:0]     i_vaddr_i,
    input  logic [`VALEN-1:0]     d_vaddr_i,
    input  logic                  st_req_i,

    // CSR state
    input  logic                  mxr_i,
    input  logic [`PPNLEN-1:0]    satp_ppn_i,
    input  logic                  flush_i,

    // Page table reads
    input  logic                  dmem_valid_i,
    input  mmu_pkg::pte_t         dmem_rdata_i,
    output logic                  dmem_req_o,
    output logic [`PALEN-1:0]     dmem_addr_o,

    // Refill towards the TLBs
    output logic                  i_refill_o,
    output logic                  d_refill_o,
    output logic [`VPNLEN-1:0]    refill_vpn_o,
    output mmu_pkg::pte_t         refill_pte_o,
    output logic                  refill_4m_o,
    output mmu_pkg::iperm_t       i_perm_o,
    output mmu_pkg::dperm_t       d_perm_o,

    output mmu_pkg::fault_t       page_fault_o
);

    import mmu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_L1_RD,
        S_L1_WT,
        S_L0_RD,
        S_L0_WT,
        S_DONE
    } state_e;

    // Control state
    state_e               state_q;
    walk_src_e            src_q;
    logic                 drop_q;
    logic                 dmem_req_q;
    logic                 i_refill_q;
    logic                 d_refill_q;
    fault_t               fault_q;

    // Walk payload
    logic [`VALEN-1:0]    vaddr_q;
    logic [`PALEN-1:0]    dmem_addr_q;
    pte_t                 pte_q;
    logic                 lvl1_q;

    logic                 rsp_ok;
    logic                 in_wait;
    logic                 at_l1;
    logic                 src_miss;
    logic                 pte_leaf;
    logic                 pte_ptr;
    logic                 fmt_bad;
    logic                 perm_bad;
    logic                 leaf_fault;
    fault_t               fault_bits;

    // A response owed to a flushed walk is swallowed
    assign rsp_ok   = dmem_valid_i & ~drop_q;
    assign in_wait  = (state_q == S_L1_WT) || (state_q == S_L0_RD) || (state_q == S_L0_WT);
    assign at_l1    = (state_q == S_L1_WT);
    assign src_miss = (src_q == WALK_I) ? i_miss_i : d_miss_i;

    assign pte_leaf = dmem_rdata_i.r | dmem_rdata_i.x;
    assign pte_ptr  = at_l1 & dmem_rdata_i.v & ~dmem_rdata_i.w & ~pte_leaf;

    // Entry format checks
    always_comb begin
        fmt_bad = !dmem_rdata_i.v || (dmem_rdata_i.w && !dmem_rdata_i.r);
        // Nothing left to walk below level 0
        if (!pte_leaf && !at_l1) begin
            fmt_bad = 1'b1;
        end
        // Superpage must be 4 MiB aligned
        if (pte_leaf && at_l1 && (dmem_rdata_i.ppn[9:0] != '0)) begin
            fmt_bad = 1'b1;
        end
    end

    // Access checks against the leaf
    always_comb begin
        if (src_q == WALK_I) begin
            perm_bad = !dmem_rdata_i.x;
        end else if (st_req_i) begin
            perm_bad = !dmem_rdata_i.w || !dmem_rdata_i.d;
        end else begin
            perm_bad = !(dmem_rdata_i.r || (dmem_rdata_i.x && mxr_i));
        end
        // No hardware A update
        perm_bad = perm_bad || !dmem_rdata_i.a;
    end

    assign leaf_fault = fmt_bad | (pte_leaf & perm_bad);

    always_comb begin
        fault_bits = '0;
        if (src_q == WALK_I) begin
            fault_bits.inst = 1'b1;
        end else if (st_req_i) begin
            fault_bits.store = 1'b1;
        end else begin
            fault_bits.load = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_IDLE;
            src_q      <= WALK_I;
            drop_q     <= 1'b0;
            dmem_req_q <= 1'b0;
            i_refill_q <= 1'b0;
            d_refill_q <= 1'b0;
            fault_q    <= '0;
        end else begin
            // All strobes are single cycle
            dmem_req_q <= 1'b0;
            i_refill_q <= 1'b0;
            d_refill_q <= 1'b0;
            fault_q    <= '0;
            if (flush_i) begin
                state_q <= S_IDLE;
                // Remember a read still in flight
                drop_q  <= dmem_valid_i ? (drop_q & in_wait) : (drop_q | in_wait);
            end else begin
                if (dmem_valid_i) begin
                    drop_q <= 1'b0;
                end
                case (state_q)
                    S_IDLE: begin
                        // Fetch side first
                        if (i_miss_i) begin
                            src_q   <= WALK_I;
                            state_q <= S_L1_RD;
                        end else if (d_miss_i) begin
                            src_q   <= WALK_D;
                            state_q <= S_L1_RD;
                        end
                    end
                    S_L1_RD: begin
                        dmem_req_q <= 1'b1;
                        state_q    <= S_L1_WT;
                    end
                    S_L1_WT, S_L0_WT: begin
                        if (rsp_ok) begin
                            if (pte_ptr) begin
                                dmem_req_q <= 1'b1;
                                state_q    <= S_L0_RD;
                            end else begin
                                state_q <= S_DONE;
                                if (leaf_fault) begin
                                    fault_q <= fault_bits;
                                end else if (src_q == WALK_I) begin
                                    i_refill_q <= 1'b1;
                                end else begin
                                    d_refill_q <= 1'b1;
                                end
                            end
                        end
                    end
                    S_L0_RD: begin
                        state_q <= S_L0_WT;
                    end
                    S_DONE: begin
                        // Hold until the requester stops missing
                        if (!src_miss) begin
                            state_q <= S_IDLE;
                        end
                    end
                    default: begin
                        state_q <= S_IDLE;
                    end
                endcase
            end
        end
    end

    // Address and entry payload
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && (i_miss_i || d_miss_i)) begin
            vaddr_q <= i_miss_i ? i_vaddr_i : d_vaddr_i;
        end
        if (state_q == S_L1_RD) begin
            dmem_addr_q <= {satp_ppn_i, vaddr_q[`VALEN-1:22], 2'b00};
        end else if (rsp_ok && pte_ptr) begin
            dmem_addr_q <= {dmem_rdata_i.ppn, vaddr_q[21:12], 2'b00};
        end
        if (rsp_ok) begin
            pte_q  <= dmem_rdata_i;
            lvl1_q <= at_l1;
        end
    end

    assign dmem_req_o   = dmem_req_q;
    assign dmem_addr_o  = dmem_addr_q;
    assign i_refill_o   = i_refill_q;
    assign d_refill_o   = d_refill_q;
    assign refill_vpn_o = vaddr_q[`VALEN-1:12];
    assign refill_pte_o = pte_q;
    // Leaf found at level 1 is a superpage
    assign refill_4m_o  = lvl1_q;
    assign i_perm_o.x   = pte_q.x;
    assign d_perm_o.r   = pte_q.r;
    assign d_perm_o.w   = pte_q.w;
    assign d_perm_o.d   = pte_q.d;
    assign page_fault_o = fault_q;

endmodule

/* logic/mmu.sv */
`include "mmu_macros.svh"

module mmu (
    input  logic                  clk,
    input  logic                  arst_n_i,

    // Instruction fetch
    input  logic                  i_req_i,
    input  logic [`VALEN-1:0]     i_vaddr_i,
    output logic                  i_hit_o,
    output logic [`PALEN-1:0]     i_paddr_o,

    // Load/store
    input  logic                  d_req_i,
    input  logic                  st_req_i,
    input  logic [`VALEN-1:0]     d_vaddr_i,
    output logic                  d_hit_o,
    output logic [`PALEN-1:0]     d_paddr_o,

    // CSR state and flush
    input  logic                  en_vaddr_i,
    input  logic                  en_ld_st_vaddr_i,
    input  logic                  mxr_i,
    input  logic [`PPNLEN-1:0]    satp_ppn_i,
    input  logic                  tlb_flush_i,

    output mmu_pkg::fault_t       page_fault_o,

    // Page table reads from data memory
    output logic                  dmem_req_o,
    output logic [`PALEN-1:0]     dmem_addr_o,
    input  logic                  dmem_valid_i,
    input  mmu_pkg::pte_t         dmem_rdata_i
);

    import mmu_pkg::*;

    logic                 i_miss;
    logic                 d_miss;
    logic                 i_refill;
    logic                 d_refill;
    logic [`VPNLEN-1:0]   refill_vpn;
    pte_t                 refill_pte;
    logic                 refill_4m;
    iperm_t               i_perm;
    dperm_t               d_perm;

    // Instruction TLB keeps only the execute bit
    tlb #(
        .perm_t         (iperm_t)
    ) itlb0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .req_i          (i_req_i),
        .vaddr_i        (i_vaddr_i),
        .en_i           (en_vaddr_i),
        .flush_i        (tlb_flush_i),
        .refill_i       (i_refill),
        .refill_vpn_i   (refill_vpn),
        .refill_pte_i   (refill_pte),
        .refill_perm_i  (i_perm),
        .refill_4m_i    (refill_4m),
        .hit_o          (i_hit_o),
        .miss_o         (i_miss),
        .paddr_o        (i_paddr_o)
    );

    // Data TLB has its own enable for MPRV-style cases
    tlb #(
        .perm_t         (dperm_t)
    ) dtlb0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .req_i          (d_req_i),
        .vaddr_i        (d_vaddr_i),
        .en_i           (en_ld_st_vaddr_i),
        .flush_i        (tlb_flush_i),
        .refill_i       (d_refill),
        .refill_vpn_i   (refill_vpn),
        .refill_pte_i   (refill_pte),
        .refill_perm_i  (d_perm),
        .refill_4m_i    (refill_4m),
        .hit_o          (d_hit_o),
        .miss_o         (d_miss),
        .paddr_o        (d_paddr_o)
    );

    // Shared walker for both TLBs
    ptw ptw0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .i_miss_i       (i_miss),
        .d_miss_i       (d_miss),
        .i_vaddr_i      (i_vaddr_i),
        .d_vaddr_i      (d_vaddr_i),
        .st_req_i       (st_req_i),
        .mxr_i          (mxr_i),
        .satp_ppn_i     (satp_ppn_i),
        .flush_i        (tlb_flush_i),
        .dmem_valid_i   (dmem_valid_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .dmem_req_o     (dmem_req_o),
        .dmem_addr_o    (dmem_addr_o),
        .i_refill_o     (i_refill),
        .d_refill_o     (d_refill),
        .refill_vpn_o   (refill_vpn),
        .refill_pte_o   (refill_pte),
        .refill_4m_o    (refill_4m),
        .i_perm_o       (i_perm),
        .d_perm_o       (d_perm),
        .page_fault_o   (page_fault_o)
    );

endmodule

/* verif/tb_mem_model.sv */
module tb_mem_model (
    input  logic         clk,
    input  logic         arst_n_i,
    input  logic         req_i,
    input  logic [33:0]  addr_i,
    input  logic [2:0]   lat_i,
    output logic         valid_o,
    output logic [31:0]  rdata_o
);

    // Index bit 10 selects the level-0 table at 0x101000
    logic [31:0] mem [2048];
    logic        busy_q;
    logic [2:0]  cnt_q;
    logic [33:0] addr_q;

    initial begin
        // Fill has V clear, so any stray entry is invalid
        for (int i = 0; i < 2048; i++) begin
            mem[i] = {i[10:0], 13'h0, i[7:0]} & 32'hffff_fffe;
        end
        // Level-1 table at 0x100000
        mem[1]    = {22'h000400, 2'b00, 8'hcf};
        mem[2]    = {22'h000101, 2'b00, 8'h01};
        mem[3]    = 32'h0;
        // Level-0 table, read-write, execute-only, read-only
        mem[1024] = {22'h000200, 2'b00, 8'hc7};
        mem[1025] = {22'h000201, 2'b00, 8'h49};
        mem[1026] = {22'h000202, 2'b00, 8'h43};
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            addr_q  <= '0;
            valid_o <= 1'b0;
            rdata_o <= '0;
        end else begin
            valid_o <= 1'b0;
            if (req_i) begin
                busy_q <= 1'b1;
                cnt_q  <= lat_i;
                addr_q <= addr_i;
            end else if (busy_q) begin
                if (cnt_q <= 3'd1) begin
                    busy_q  <= 1'b0;
                    valid_o <= 1'b1;
                    rdata_o <= mem[addr_q[12:2]];
                end else begin
                    cnt_q <= cnt_q - 3'd1;
                end
            end
        end
    end

endmodule

/* verif/tb_mmu.sv */
module tb_mmu;

    import mmu_pkg::*;

    logic         clk;
    logic         arst_n;
    logic         i_req;
    logic         d_req;
    logic         st_req;
    logic [31:0]  i_vaddr;
    logic [31:0]  d_vaddr;
    logic         en_vaddr;
    logic         en_ld_st;
    logic         mxr;
    logic [21:0]  satp_ppn;
    logic         flush;
    logic         i_hit;
    logic         d_hit;
    logic [33:0]  i_paddr;
    logic [33:0]  d_paddr;
    fault_t       fault;
    logic         dmem_req;
    logic [33:0]  dmem_addr;
    logic         dmem_valid;
    logic [31:0]  dmem_rdata;
    logic [2:0]   mem_lat;

    // Expected values and bookkeeping
    logic [31:0]  lfsr_q;
    logic [33:0]  exp_strobe [4];
    logic [33:0]  exp_addr_now;
    logic [33:0]  exp_i_paddr;
    logic [33:0]  exp_d_paddr;
    fault_t       exp_fault;
    int           exp_nstrobe;
    int           strobe_base;
    int           strobe_cnt;
    int           strobe_idx;
    int           err_cnt;
    int           fault_cnt;
    int           cycles;
    logic [11:0]  off;

    mmu dut0 (
        .clk(clk), .arst_n_i(arst_n),
        .i_req_i(i_req), .i_vaddr_i(i_vaddr), .i_hit_o(i_hit), .i_paddr_o(i_paddr),
        .d_req_i(d_req), .st_req_i(st_req), .d_vaddr_i(d_vaddr),
        .d_hit_o(d_hit), .d_paddr_o(d_paddr),
        .en_vaddr_i(en_vaddr), .en_ld_st_vaddr_i(en_ld_st), .mxr_i(mxr),
        .satp_ppn_i(satp_ppn), .tlb_flush_i(flush), .page_fault_o(fault),
        .dmem_req_o(dmem_req), .dmem_addr_o(dmem_addr),
        .dmem_valid_i(dmem_valid), .dmem_rdata_i(dmem_rdata)
    );

    tb_mem_model mem0 (
        .clk(clk), .arst_n_i(arst_n), .req_i(dmem_req), .addr_i(dmem_addr),
        .lat_i(mem_lat), .valid_o(dmem_valid), .rdata_o(dmem_rdata)
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        return lfsr_q[0];
    endfunction

    // Memory latency of 2 to 4 cycles
    always @(negedge clk) begin
        mem_lat <= 3'd2 + {2'b00, lfsr_bit()} + {2'b00, lfsr_bit()};
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (dmem_req) begin
            strobe_cnt <= strobe_cnt + 1;
        end
        if (page_fault_any()) begin
            fault_cnt <= fault_cnt + 1;
        end
        if (cycles == 2000) begin
            $display("Timeout: the run did not finish within 2000 cycles");
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic page_fault_any();
        return fault.inst | fault.load | fault.store;
    endfunction

    assign strobe_idx   = strobe_cnt - strobe_base;
    assign exp_addr_now = (strobe_idx >= 0 && strobe_idx < 4) ? exp_strobe[strobe_idx[1:0]] : '0;

    assert property (@(posedge clk) disable iff (!arst_n) i_hit |-> i_paddr == exp_i_paddr)
        else begin
            err_cnt++;
            $display("[ERROR] i_paddr_o expected %h got %h",
                     $sampled(exp_i_paddr), $sampled(i_paddr));
        end

    assert property (@(posedge clk) disable iff (!arst_n) d_hit |-> d_paddr == exp_d_paddr)
        else begin
            err_cnt++;
            $display("[ERROR] d_paddr_o expected %h got %h",
                     $sampled(exp_d_paddr), $sampled(d_paddr));
        end

    assert property (@(posedge clk) disable iff (!arst_n) dmem_req |-> strobe_idx < exp_nstrobe)
        else begin
            err_cnt++;
            $display("Memory read strobe seen where no page table read was expected");
        end

    assert property (@(posedge clk) disable iff (!arst_n)
                     (dmem_req && strobe_idx < exp_nstrobe) |-> dmem_addr == exp_addr_now)
        else begin
            err_cnt++;
            $display("[ERROR] dmem_addr_o expected %h got %h",
                     $sampled(exp_addr_now), $sampled(dmem_addr));
        end

    assert property (@(posedge clk) disable iff (!arst_n)
                     (fault != '0) |-> fault == exp_fault)
        else begin
            err_cnt++;
            $display("[ERROR] page_fault_o expected %h got %h",
                     $sampled(exp_fault), $sampled(fault));
        end

    // Arms the expected strobe sequence for the next walk
    task automatic expect_walk(input int n, input logic [33:0] a0, input logic [33:0] a1,
                               input logic [33:0] a2);
        exp_nstrobe   <= n;
        strobe_base   <= strobe_cnt;
        exp_strobe[0] <= a0;
        exp_strobe[1] <= a1;
        exp_strobe[2] <= a2;
        exp_fault     <= '0;
    endtask

    task automatic rand_offset();
        for (int b = 0; b < 12; b++) begin
            off[b] = lfsr_bit();
        end
    endtask

    task automatic release_reqs();
        @(posedge clk);
        i_req  <= 1'b0;
        d_req  <= 1'b0;
        st_req <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_result(input logic want_i, input logic want_d);
        logic got_i;
        logic got_d;
        got_i = !want_i;
        got_d = !want_d;
        while (!(got_i && got_d)) begin
            @(negedge clk);
            if (i_hit || fault.inst) got_i = 1'b1;
            if (d_hit || fault.load || fault.store) got_d = 1'b1;
        end
        assert (strobe_cnt - strobe_base == exp_nstrobe)
            else begin
                err_cnt++;
                $display("Walk made %0d memory reads, %0d were expected",
                         strobe_cnt - strobe_base, exp_nstrobe);
            end
    endtask

    // One data access to a level-0 page k
    task automatic data_access(input int k, input logic st, input int n, input fault_t f);
        @(posedge clk);
        rand_offset();
        d_req       <= 1'b1;
        st_req      <= st;
        d_vaddr     <= {10'd2, k[9:0], off};
        expect_walk(n, 34'h100008, {22'h000101, k[9:0], 2'b00}, '0);
        exp_d_paddr <= (f != '0) ? '1 : {22'h000200 + 22'(k), off};
        if (f != '0) exp_fault <= f;
        wait_result(1'b0, 1'b1);
        release_reqs();
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        lfsr_q      = 32'h40a9;
        i_req       = 1'b0;
        d_req       = 1'b0;
        st_req      = 1'b0;
        i_vaddr     = '0;
        d_vaddr     = '0;
        en_vaddr    = 1'b0;
        en_ld_st    = 1'b0;
        mxr         = 1'b0;
        satp_ppn    = 22'h000100;
        flush       = 1'b0;
        mem_lat     = 3'd2;
        exp_nstrobe = 0;
        strobe_base = 0;
        strobe_cnt  = 0;
        err_cnt     = 0;
        fault_cnt   = 0;
        cycles      = 0;
        exp_fault   = '0;
        exp_i_paddr = '0;
        exp_d_paddr = '0;
        off         = '0;
        for (int j = 0; j < 4; j++) begin
            exp_strobe[j] = '0;
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // Bypass on both sides
        @(posedge clk);
        i_req       <= 1'b1;
        d_req       <= 1'b1;
        i_vaddr     <= 32'h8123_4567;
        d_vaddr     <= 32'hc0de_0abc;
        exp_i_paddr <= 34'h0_8123_4567;
        exp_d_paddr <= 34'h0_c0de_0abc;
        @(negedge clk);
        assert (i_hit && d_hit) else begin
            err_cnt++;
            $display("Bypass request did not hit in the same cycle");
        end
        release_reqs();
        en_vaddr <= 1'b1;
        en_ld_st <= 1'b1;

        // 4K walk and then a repeated hit without memory reads
        data_access(0, 1'b0, 2, '0);
        @(posedge clk);
        d_req <= 1'b1;
        expect_walk(0, '0, '0, '0);
        wait_result(1'b0, 1'b1);
        release_reqs();

        // 4M walk through the fetch side
        @(posedge clk);
        rand_offset();
        i_req       <= 1'b1;
        i_vaddr     <= {10'd1, 10'h2a5, off};
        expect_walk(1, 34'h100004, '0, '0);
        exp_i_paddr <= {12'h001, 10'h2a5, off};
        wait_result(1'b1, 1'b0);
        release_reqs();

        // Fetch to the read-only page
        @(posedge clk);
        i_req       <= 1'b1;
        i_vaddr     <= {10'd2, 10'd2, 12'h010};
        expect_walk(2, 34'h100008, 34'h101008, '0);
        exp_i_paddr <= '1;
        exp_fault   <= '{inst: 1'b1, load: 1'b0, store: 1'b0};
        wait_result(1'b1, 1'b0);
        release_reqs();

        data_access(1, 1'b1, 2, '{inst: 1'b0, load: 1'b0, store: 1'b1});
        data_access(1, 1'b0, 2, '{inst: 1'b0, load: 1'b1, store: 1'b0});
        mxr <= 1'b1;
        data_access(1, 1'b0, 2, '0);
        mxr <= 1'b0;

        // Invalid level-1 entry
        @(posedge clk);
        d_req       <= 1'b1;
        d_vaddr     <= {10'd3, 22'h0};
        expect_walk(1, 34'h10000c, '0, '0);
        exp_d_paddr <= '1;
        exp_fault   <= '{inst: 1'b0, load: 1'b1, store: 1'b0};
        wait_result(1'b0, 1'b1);
        release_reqs();

        // Flush makes a cached page walk again
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        data_access(0, 1'b0, 2, '0);

        // Both miss together and the fetch is walked first
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(posedge clk);
        rand_offset();
        i_req       <= 1'b1;
        d_req       <= 1'b1;
        i_vaddr     <= {10'd1, 10'h011, off};
        d_vaddr     <= {10'd2, 10'd0, ~off};
        expect_walk(3, 34'h100004, 34'h100008, 34'h101000);
        exp_i_paddr <= {12'h001, 10'h011, off};
        exp_d_paddr <= {22'h000200, ~off};
        wait_result(1'b1, 1'b1);
        release_reqs();

        repeat (2) @(posedge clk);
        $display("Summary: %0d errors, %0d memory reads, %0d faults, %0d cycles",
                 err_cnt, strobe_cnt, fault_cnt, cycles);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/mmu_pkg.sv
logic/tlb.sv
logic/ptw.sv
logic/mmu.sv
verif/tb_mem_model.sv
verif/tb_mmu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MMU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu -f src.f || exit 1
out=$(./obj_dir/Vtb_mmu) || true
echo "$out"
echo "$out" | grep -qxF '** PASS **' && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
